// ==== sources.f ====
+incdir+test
src/drbe_pkg.sv
src/local_ctrl.sv
src/tap_addr_gen.sv
src/sample_ram.sv
src/packet_former.sv
src/delay_tap_top.sv
test/delay_tap_sva.sv
test/delay_tap_tb.sv

// ==== Makefile ====
BIN := obj_dir/Vdelay_tap_tb
SRCS := $(filter-out +incdir+%,$(shell cat sources.f)) test/delay_tap_tests.svh

.PHONY: all run clean

all: run

$(BIN): sources.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module delay_tap_tb -f sources.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

// ==== test/delay_tap_tests.svh ====
`ifndef DELAY_TAP_TESTS_SVH
`define DELAY_TAP_TESTS_SVH

// tap config in its own cycle, armed on the next falling edge
task automatic configure(input logic [ADDR_W-1:0] d, input logic [DEST_W-1:0] dst);
	step(1'b0);
	cfg_valid = 1'b1;
	cfg_delay = d;
	cfg_dest = dst;
	armed_m = 1'b1;
	delay_m = d;
	dest_m = dst;
	step(1'b0);
	check_bit("tap_armed", tap_armed, 1'b1);
endtask

// idle after reset while the whole store is filled
task automatic test_fill();
	repeat (DEPTH) begin
		step(1'b1);
		check_bit("tap_armed", tap_armed, 1'b0);
		check_bit("prefetch_valid_out", prefetch_valid_out, 1'b0);
		check_bit("prefetch_done", prefetch_done, 1'b0);
	end
endtask

task automatic test_tap_delay();
	configure(8'd25, 8'h08);
	repeat (40) step(1'b1);
	repeat (3) step(1'b0);
endtask

// delay 0 reads the entry about to be overwritten, 256 writes back
task automatic test_short_delays();
	configure(8'd1, 8'h08);
	for (int i = 0; i < 30; i++)
		step(i % 3 != 2);
	configure(8'd0, 8'h08);
	for (int i = 0; i < 30; i++)
		step(i % 4 != 1);
	repeat (3) step(1'b0);
endtask

// first packet on the third falling edge after the request
task automatic prefetch_run(input logic [ADDR_W-1:0] start, stop,
		input logic [DEST_W-1:0] dst, input int n, input logic retry);
	logic [ADDR_W-1:0] a;
	a = start;
	step(1'b0);
	prefetch_valid = 1'b1;
	prefetch_start = start;
	prefetch_stop = stop;
	prefetch_dest = dst;
	step(1'b0);
	step(1'b0);
	check_bit("prefetch_valid_out", prefetch_valid_out, 1'b0);
	for (int i = 0; i < n; i++) begin
		step(1'b0);
		// request in the middle of a run, must be dropped
		if (retry && i == 20) begin
			prefetch_valid = 1'b1;
			prefetch_start = 8'h90;
		end
		check_bit("prefetch_valid_out", prefetch_valid_out, 1'b1);
		check_bit("prefetch_done", prefetch_done, i == n - 1);
		check_packet("prefetch_packet_out", prefetch_packet_out, {dst, model[a]});
		a++;
	end
	step(1'b0);
	check_bit("prefetch_valid_out", prefetch_valid_out, 1'b0);
	check_bit("prefetch_done", prefetch_done, 1'b0);
endtask

task automatic test_prefetch();
	prefetch_run(8'h30, 8'he0, 8'h6f, 177, 1'b1);
	prefetch_run(8'hfe, 8'h01, 8'h6f, 4, 1'b0);
endtask

// update cancels tap and prefetch, write pointer survives it
task automatic test_scenario_update();
	configure(8'd10, 8'h33);
	prefetch_valid = 1'b1;
	prefetch_start = 8'h00;
	prefetch_stop = 8'hff;
	repeat (8) step(1'b1);
	armed_m = 1'b0;
	step(1'b1);
	scenario_update = 1'b1;
	check_bit("prefetch_valid_out", prefetch_valid_out, 1'b1);
	step(1'b1);
	check_bit("tap_armed", tap_armed, 1'b0);
	repeat (12) begin
		step(1'b1);
		check_bit("prefetch_valid_out", prefetch_valid_out, 1'b0);
		check_bit("prefetch_done", prefetch_done, 1'b0);
	end
	configure(8'd10, 8'h33);
	repeat (30) step(1'b1);
	repeat (3) step(1'b0);
endtask

`endif

// ==== test/delay_tap_tb.sv ====
`timescale 1ns/1ps

module delay_tap_tb;
	import drbe_pkg::*;

	// reset, fill, tap, short delays, prefetch, scenario update, drain
	localparam int RUN_CYCLES = 10 + 256 + 45 + 67 + 189 + 59 + 4;

	logic CLK = 1'b0;
	logic reset;
	logic write_en, cfg_valid, prefetch_valid, scenario_update;
	logic [SAMPLE_W-1:0] sample_in;
	logic [ADDR_W-1:0] cfg_delay, prefetch_start, prefetch_stop;
	logic [DEST_W-1:0] cfg_dest, prefetch_dest;
	logic [PACKET_W-1:0] packet_out, prefetch_packet_out;
	logic packet_valid, prefetch_valid_out, prefetch_done, tap_armed;

	// reference store, indexed like the DUT write pointer
	logic [SAMPLE_W-1:0] model [DEPTH];
	logic [ADDR_W-1:0] wr_count = '0;
	logic [ADDR_W-1:0] delay_m = '0;
	logic [DEST_W-1:0] dest_m = '0;
	logic armed_m = 1'b0;
	logic [31:0] lfsr = 32'h16b5_1a2f;
	logic [PACKET_W-1:0] tap_exp [$];
	int tap_due [$];
	int cyc = 0;
	int checks = 0;
	int errors = 0;

	delay_tap_top i_delay_tap_top (.*);

	always #5 CLK = ~CLK;

	always @(posedge CLK)
		cyc <= cyc + 1;

	//////////////////////////////
	// compare tasks
	//////////////////////////////
	task automatic check_packet(input string name, input logic [PACKET_W-1:0] got, exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// tap packets leave in write order, due two falling edges after the write
	always @(negedge CLK) begin
		if (!reset && packet_valid) begin
			if (tap_exp.size() == 0) begin
				errors++;
				$display("tap packet at cycle %0d with no write to match it", cyc);
			end else begin
				if (tap_due[0] != cyc) begin
					errors++;
					$display("tap packet at cycle %0d, due at cycle %0d", cyc, tap_due[0]);
				end
				check_packet("packet_out", packet_out, tap_exp.pop_front());
				void'(tap_due.pop_front());
			end
		end else if (tap_due.size() != 0 && tap_due[0] <= cyc) begin
			errors++;
			$display("tap packet due at cycle %0d never arrived", tap_due[0]);
			void'(tap_exp.pop_front());
			void'(tap_due.pop_front());
		end
	end

	//////////////////////////////
	// stimulus helpers
	//////////////////////////////

	// 32-bit fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [SAMPLE_W-1:0] random_sample();
		logic [SAMPLE_W-1:0] v;
		for (int i = 0; i < SAMPLE_W; i++) begin
			lfsr = lfsr_next(lfsr);
			v[i] = lfsr[0];
		end
		return v;
	endfunction

	// one falling edge, strobes cleared, a write mirrored in the model
	task automatic step(input logic en);
		logic [ADDR_W-1:0] rd;
		@(negedge CLK);
		cfg_valid = 1'b0;
		prefetch_valid = 1'b0;
		scenario_update = 1'b0;
		write_en = en;
		if (en) begin
			sample_in = random_sample();
			rd = wr_count - delay_m;
			if (armed_m) begin
				tap_exp.push_back({dest_m, model[rd]});
				tap_due.push_back(cyc + 2);
			end
			model[wr_count] = sample_in;
			wr_count++;
		end
	endtask

	`include "delay_tap_tests.svh"

	initial begin
		reset = 1'b1;
		write_en = 1'b0;
		sample_in = '0;
		cfg_valid = 1'b0;
		cfg_delay = '0;
		cfg_dest = '0;
		prefetch_valid = 1'b0;
		prefetch_start = '0;
		prefetch_stop = '0;
		prefetch_dest = '0;
		scenario_update = 1'b0;
		repeat (10) @(negedge CLK);
		reset = 1'b0;
		test_fill();
		test_tap_delay();
		test_short_delays();
		test_prefetch();
		test_scenario_update();
		repeat (4) step(1'b0);
		if (tap_exp.size() != 0) begin
			errors++;
			$display("%0d tap packets still outstanding at end of run", tap_exp.size());
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	// watchdog
	initial begin
		#((RUN_CYCLES + 200) * 10);
		$display("watchdog expired at cycle %0d, tests did not finish", cyc);
		$display("TB FAILED");
		$finish;
	end

endmodule

// ==== test/delay_tap_sva.sv ====
`timescale 1ns/1ps

module delay_tap_sva (
	input logic CLK,
	input logic reset,
	input logic packet_valid,
	input logic prefetch_valid_out,
	input logic prefetch_done,
	input logic tap_armed
);
	import drbe_pkg::*;

	// a tap packet comes from a read issued while armed
	tap_needs_armed: assert property (@(posedge CLK) disable iff (reset)
		packet_valid |-> $past(tap_armed))
		else $error("packet_valid high with tap_armed low the cycle before");

	// done rides on the last packet of a run
	prefetch_done_with_valid: assert property (@(posedge CLK) disable iff (reset)
		$past(prefetch_done) |-> $past(prefetch_valid_out) && !prefetch_valid_out)
		else $error("prefetch_done not on the last prefetch packet");

	// strobes leave a reset edge low
	strobes_low_in_reset: assert property (@(posedge CLK)
		reset |=> !(packet_valid || prefetch_valid_out || prefetch_done))
		else $error("output strobe high during reset");

endmodule

bind delay_tap_top delay_tap_sva i_delay_tap_sva (.*);

// ==== src/delay_tap_top.sv ====
`timescale 1ns/1ps

module delay_tap_top (
	input  logic                          CLK,
	input  logic                          reset,
	input  logic [drbe_pkg::SAMPLE_W-1:0] sample_in,
	input  logic                          write_en,
	input  logic                          cfg_valid,
	input  logic [drbe_pkg::ADDR_W-1:0]   cfg_delay,
	input  logic [drbe_pkg::DEST_W-1:0]   cfg_dest,
	input  logic                          prefetch_valid,
	input  logic [drbe_pkg::ADDR_W-1:0]   prefetch_start,
	input  logic [drbe_pkg::ADDR_W-1:0]   prefetch_stop,
	input  logic [drbe_pkg::DEST_W-1:0]   prefetch_dest,
	input  logic                          scenario_update,
	output logic [drbe_pkg::PACKET_W-1:0] packet_out,
	output logic                          packet_valid,
	output logic [drbe_pkg::PACKET_W-1:0] prefetch_packet_out,
	output logic                          prefetch_valid_out,
	output logic                          prefetch_done,
	output logic                          tap_armed
);
	import drbe_pkg::*;

	logic [ADDR_W-1:0]   tap_delay;
	logic [DEST_W-1:0]   tap_dest;
	logic                stream_en;
	logic                pf_load;
	logic                pf_run;
	logic [DEST_W-1:0]   pf_dest;
	logic [ADDR_W-1:0]   pf_stop;
	logic                pf_last;
	logic                pf_last_q;
	logic [ADDR_W-1:0]   wr_addr;
	logic [ADDR_W-1:0]   tap_addr;
	logic [ADDR_W-1:0]   pf_addr;
	logic [SAMPLE_W-1:0] tap_data;
	logic [SAMPLE_W-1:0] pf_data;

	//////////////////////////////
	// control
	//////////////////////////////
	local_ctrl i_local_ctrl (
		.CLK(CLK), .reset(reset), .write_en(write_en),
		.cfg_valid(cfg_valid), .cfg_delay(cfg_delay), .cfg_dest(cfg_dest),
		.prefetch_valid(prefetch_valid), .prefetch_stop(prefetch_stop),
		.prefetch_dest(prefetch_dest), .scenario_update(scenario_update),
		.pf_last(pf_last), .tap_delay(tap_delay), .tap_dest(tap_dest),
		.stream_en(stream_en), .pf_load(pf_load), .pf_run(pf_run),
		.pf_dest(pf_dest), .pf_stop(pf_stop), .pf_last_q(pf_last_q),
		.tap_armed(tap_armed)
	);

	//////////////////////////////
	// datapath
	//////////////////////////////
	tap_addr_gen i_tap_addr_gen (
		.CLK(CLK), .reset(reset), .write_en(write_en), .stream_en(stream_en),
		.tap_delay(tap_delay), .pf_load(pf_load), .pf_run(pf_run),
		.prefetch_start(prefetch_start), .pf_stop(pf_stop),
		.wr_addr(wr_addr), .tap_addr(tap_addr), .pf_addr(pf_addr), .pf_last(pf_last)
	);

	sample_ram i_sample_ram (
		.CLK(CLK), .write_en(write_en), .wr_addr(wr_addr), .sample_in(sample_in),
		.tap_rd(stream_en), .tap_addr(tap_addr), .pf_rd(pf_run), .pf_addr(pf_addr),
		.tap_data(tap_data), .pf_data(pf_data)
	);

	packet_former i_packet_former (
		.CLK(CLK), .reset(reset), .tap_rd(stream_en), .tap_dest(tap_dest),
		.tap_data(tap_data), .pf_rd(pf_run), .pf_dest(pf_dest), .pf_data(pf_data),
		.pf_last_q(pf_last_q), .scenario_update(scenario_update),
		.packet_out(packet_out), .packet_valid(packet_valid),
		.prefetch_packet_out(prefetch_packet_out),
		.prefetch_valid_out(prefetch_valid_out), .prefetch_done(prefetch_done)
	);

endmodule

// ==== src/packet_former.sv ====
`timescale 1ns/1ps

module packet_former (
	input  logic                          CLK,
	input  logic                          reset,
	input  logic                          tap_rd,
	input  logic [drbe_pkg::DEST_W-1:0]   tap_dest,
	input  logic [drbe_pkg::SAMPLE_W-1:0] tap_data,
	input  logic                          pf_rd,
	input  logic [drbe_pkg::DEST_W-1:0]   pf_dest,
	input  logic [drbe_pkg::SAMPLE_W-1:0] pf_data,
	input  logic                          pf_last_q,
	input  logic                          scenario_update,
	output logic [drbe_pkg::PACKET_W-1:0] packet_out,
	output logic                          packet_valid,
	output logic [drbe_pkg::PACKET_W-1:0] prefetch_packet_out,
	output logic                          prefetch_valid_out,
	output logic                          prefetch_done
);
	import drbe_pkg::*;

	logic              tap_rd_q;
	logic              pf_rd_q;
	logic [DEST_W-1:0] tap_dest_q;
	logic [DEST_W-1:0] pf_dest_q;

	// strobes follow the one-cycle store read
	// scenario change drops the read issued in the same cycle
	always_ff @(posedge CLK) begin
		if (reset) begin
			tap_rd_q           <= 1'b0;
			pf_rd_q            <= 1'b0;
			packet_valid       <= 1'b0;
			prefetch_valid_out <= 1'b0;
			prefetch_done      <= 1'b0;
		end else begin
			tap_rd_q           <= tap_rd & ~scenario_update;
			pf_rd_q            <= pf_rd & ~scenario_update;
			packet_valid       <= tap_rd_q;
			prefetch_valid_out <= pf_rd_q;
			prefetch_done      <= pf_rd_q & pf_last_q;
		end
	end

	// destinations ride along with their read
	always_ff @(posedge CLK) begin
		tap_dest_q <= tap_dest;
		pf_dest_q  <= pf_dest;
		if (tap_rd_q)
			packet_out <= {tap_dest_q, tap_data};
		if (pf_rd_q)
			prefetch_packet_out <= {pf_dest_q, pf_data};
	end

endmodule

// ==== src/sample_ram.sv ====
`timescale 1ns/1ps

module sample_ram (
	input  logic                          CLK,
	input  logic                          write_en,
	input  logic [drbe_pkg::ADDR_W-1:0]   wr_addr,
	input  logic [drbe_pkg::SAMPLE_W-1:0] sample_in,
	input  logic                          tap_rd,
	input  logic [drbe_pkg::ADDR_W-1:0]   tap_addr,
	input  logic                          pf_rd,
	input  logic [drbe_pkg::ADDR_W-1:0]   pf_addr,
	output logic [drbe_pkg::SAMPLE_W-1:0] tap_data,
	output logic [drbe_pkg::SAMPLE_W-1:0] pf_data
);
	import drbe_pkg::*;

	logic [SAMPLE_W-1:0] mem [DEPTH];

	// read before write, a colliding read sees the old sample
	always_ff @(posedge CLK) begin
		if (write_en)
			mem[wr_addr] <= sample_in;
		if (tap_rd)
			tap_data <= mem[tap_addr];
		if (pf_rd)
			pf_data <= mem[pf_addr];
	end

endmodule

// ==== src/tap_addr_gen.sv ====
`timescale 1ns/1ps

module tap_addr_gen (
	input  logic                        CLK,
	input  logic                        reset,
	input  logic                        write_en,
	input  logic                        stream_en,
	input  logic [drbe_pkg::ADDR_W-1:0] tap_delay,
	input  logic                        pf_load,
	input  logic                        pf_run,
	input  logic [drbe_pkg::ADDR_W-1:0] prefetch_start,
	input  logic [drbe_pkg::ADDR_W-1:0] pf_stop,
	output logic [drbe_pkg::ADDR_W-1:0] wr_addr,
	output logic [drbe_pkg::ADDR_W-1:0] tap_addr,
	output logic [drbe_pkg::ADDR_W-1:0] pf_addr,
	output logic                        pf_last
);
	import drbe_pkg::*;

	logic [ADDR_W-1:0] wr_ptr;
	logic [ADDR_W-1:0] tap_next;
	logic [ADDR_W-1:0] tap_park;
	logic [ADDR_W-1:0] pf_cnt;

	//////////////////////////////
	// write side
	//////////////////////////////

	// wraps at DEPTH by width
	always_ff @(posedge CLK) begin
		if (reset)
			wr_ptr <= '0;
		else if (write_en)
			wr_ptr <= wr_ptr + 1'b1;
	end

	assign wr_addr = wr_ptr;

	//////////////////////////////
	// tap read address
	//////////////////////////////

	// delay 0 lands on the entry about to be overwritten, i.e. 256 back
	assign tap_next = wr_ptr - tap_delay;

	// address held at its last value while the tap port is idle
	always_ff @(posedge CLK) begin
		if (reset)
			tap_park <= '0;
		else if (stream_en)
			tap_park <= tap_next;
	end

	assign tap_addr = stream_en ? tap_next : tap_park;

	//////////////////////////////
	// prefetch walk
	//////////////////////////////
	always_ff @(posedge CLK) begin
		if (reset)
			pf_cnt <= '0;
		else if (pf_load)
			pf_cnt <= prefetch_start;
		else if (pf_run)
			pf_cnt <= pf_cnt + 1'b1;
	end

	assign pf_addr = pf_cnt;
	assign pf_last = (pf_cnt == pf_stop);

endmodule

// ==== src/local_ctrl.sv ====
`timescale 1ns/1ps

module local_ctrl (
	input  logic                        CLK,
	input  logic                        reset,
	input  logic                        write_en,
	input  logic                        cfg_valid,
	input  logic [drbe_pkg::ADDR_W-1:0] cfg_delay,
	input  logic [drbe_pkg::DEST_W-1:0] cfg_dest,
	input  logic                        prefetch_valid,
	input  logic [drbe_pkg::ADDR_W-1:0] prefetch_stop,
	input  logic [drbe_pkg::DEST_W-1:0] prefetch_dest,
	input  logic                        scenario_update,
	input  logic                        pf_last,
	output logic [drbe_pkg::ADDR_W-1:0] tap_delay,
	output logic [drbe_pkg::DEST_W-1:0] tap_dest,
	output logic                        stream_en,
	output logic                        pf_load,
	output logic                        pf_run,
	output logic [drbe_pkg::DEST_W-1:0] pf_dest,
	output logic [drbe_pkg::ADDR_W-1:0] pf_stop,
	output logic                        pf_last_q,
	output logic                        tap_armed
);
	import drbe_pkg::*;

	logic [1:0] pf_state;
	logic [1:0] pf_state_next;

	//////////////////////////////
	// tap configuration
	//////////////////////////////

	// scenario change wins over a new config in the same cycle
	always_ff @(posedge CLK) begin
		if (reset || scenario_update) begin
			tap_armed <= 1'b0;
			tap_delay <= '0;
			tap_dest  <= '0;
		end else if (cfg_valid) begin
			tap_armed <= 1'b1;
			tap_delay <= cfg_delay;
			tap_dest  <= cfg_dest;
		end
	end

	// one tap read per written sample
	assign stream_en = tap_armed & write_en;

	//////////////////////////////
	// prefetch fsm
	//////////////////////////////

	// requests only taken while idle
	assign pf_load = (pf_state == PF_IDLE) & prefetch_valid;
	assign pf_run  = (pf_state == PF_LOAD) || (pf_state == PF_RUN);

	always_comb begin
		pf_state_next = pf_state;
		case (pf_state)
			PF_IDLE: begin
				if (prefetch_valid)
					pf_state_next = PF_LOAD;
			end
			// counter holds start here, a one-entry range ends at once
			PF_LOAD: begin
				pf_state_next = pf_last ? PF_IDLE : PF_RUN;
			end
			PF_RUN: begin
				if (pf_last)
					pf_state_next = PF_IDLE;
			end
			default: begin
				pf_state_next = PF_IDLE;
			end
		endcase
		if (scenario_update)
			pf_state_next = PF_IDLE;
	end

	always_ff @(posedge CLK) begin
		if (reset)
			pf_state <= PF_IDLE;
		else
			pf_state <= pf_state_next;
	end

	// stop and destination latched with the request
	always_ff @(posedge CLK) begin
		if (reset) begin
			pf_stop <= '0;
			pf_dest <= '0;
		end else if (pf_load) begin
			pf_stop <= prefetch_stop;
			pf_dest <= prefetch_dest;
		end
	end

	// last flag lines up with the registered read data
	always_ff @(posedge CLK) begin
		if (reset)
			pf_last_q <= 1'b0;
		else
			pf_last_q <= pf_run & pf_last;
	end

endmodule

// ==== src/drbe_pkg.sv ====
package drbe_pkg;

	//////////////////////////////
	// datapath widths
	//////////////////////////////

	// one I/Q sample, 16-bit I in the upper half, 16-bit Q in the lower
	localparam int SAMPLE_W = 32;

	// sample store address
	localparam int ADDR_W = 8;

	// destination address vector
	localparam int DEST_W = 8;

	// packet is destination on top, sample below
	localparam int PACKET_W = DEST_W + SAMPLE_W;

	// store entries, one per address
	localparam int DEPTH = 256;

	//////////////////////////////
	// prefetch fsm encoding
	//////////////////////////////
	localparam logic [1:0] PF_IDLE = 2'd0;
	localparam logic [1:0] PF_LOAD = 2'd1;
	localparam logic [1:0] PF_RUN  = 2'd2;

endpackage
